// File: line_code_pkg.sv
package line_code_pkg;

	// Plain character before encoding
	typedef logic [7:0] byte_t;

	typedef logic [9:0] symbol_t; // abcdei in [9:4], fghj in [3:0]

	typedef logic [31:0] crc_t; // Ethernet CRC-32

	// Framer states
	typedef enum logic [2:0] {
		IDLE, // Waiting for the first comma
		PREAMBLE, // Counting commas
		PAYLOAD, // Forwarding user characters
		CRC_TAIL, // Four CRC bytes
		CLOSE // Closing K28.5
	} frame_state_t;

	// 9-bit input character
	typedef struct packed {
		logic is_k; // Control character flag
		byte_t value; // HGF EDCBA
	} char_t;

	// Strobed stream from framer to encoder
	typedef struct packed {
		logic valid; // Character present this cycle
		logic start; // First comma of a frame
		char_t ch;
	} code_t;

	localparam byte_t K28_1 = 8'h3C; // Comma
	localparam byte_t K28_5 = 8'hBC; // Closing character
	localparam byte_t K23_7 = 8'hF7; // End of payload

	// Low five bits common to all K28.y
	localparam logic [4:0] K28_X = 5'd28;

endpackage

// File: crc32_accum.sv
`timescale 1ns/1ns

module crc32_accum (
	input logic clk,
	input logic reset,
	input logic crc_clear, // Frame start
	input logic crc_update, // Payload data byte present
	input line_code_pkg::byte_t data,
	output line_code_pkg::crc_t crc_value
);
	localparam line_code_pkg::crc_t CRC_POLY = 32'hEDB8_8320; // Reflected 0x04C11DB7
	localparam line_code_pkg::crc_t CRC_INIT = 32'hFFFF_FFFF;

	line_code_pkg::crc_t crc_reg;

	// One byte, LSB first
	function automatic line_code_pkg::crc_t fold_byte(input line_code_pkg::crc_t crc,
			input line_code_pkg::byte_t b);
		line_code_pkg::crc_t c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ b[i]) begin
				c = (c >> 1) ^ CRC_POLY; // Feedback tap
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	always_ff @(posedge clk) begin
		if (reset || crc_clear) begin
			crc_reg <= CRC_INIT; // Preset to all ones
		end else if (crc_update) begin
			crc_reg <= fold_byte(crc_reg, data);
		end
	end

	assign crc_value = ~crc_reg; // Final complement
endmodule

// File: frame_ctrl.sv
`timescale 1ns/1ns

module frame_ctrl #(
	parameter int PREAMBLE_LEN = 4
) (
	input logic clk,
	input logic reset,
	input logic pushin,
	input logic startin,
	input line_code_pkg::char_t datain,
	input line_code_pkg::crc_t crc_value, // Already complemented
	output logic crc_clear,
	output logic crc_update,
	output line_code_pkg::byte_t crc_byte,
	output line_code_pkg::code_t char_stream
);
	localparam int CNT_W = $clog2(PREAMBLE_LEN + 1);

	line_code_pkg::frame_state_t state;
	logic [CNT_W-1:0] comma_cnt; // Commas seen so far
	logic [1:0] crc_idx; // Tail byte, LSB first
	logic is_comma;
	logic is_end;

	assign is_comma = datain.is_k && (datain.value == line_code_pkg::K28_1);
	assign is_end = datain.is_k && (datain.value == line_code_pkg::K23_7);

	// First comma with startin opens a frame
	assign crc_clear = pushin && startin && is_comma && (state == line_code_pkg::IDLE);
	// Control characters stay out of the CRC
	assign crc_update = pushin && !datain.is_k && (state == line_code_pkg::PAYLOAD);
	assign crc_byte = datain.value;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= line_code_pkg::IDLE;
			comma_cnt <= '0;
			crc_idx <= '0;
			char_stream.valid <= 1'b0;
			char_stream.start <= 1'b0;
		end else begin
			char_stream.valid <= 1'b0; // Strobes by default
			char_stream.start <= 1'b0;
			case (state)
				line_code_pkg::IDLE: begin
					if (crc_clear) begin
						char_stream.valid <= 1'b1;
						char_stream.start <= 1'b1; // Marks first comma
						char_stream.ch <= datain;
						comma_cnt <= CNT_W'(1);
						state <= line_code_pkg::PREAMBLE;
					end
				end
				line_code_pkg::PREAMBLE: begin
					if (pushin) begin
						if (is_comma) begin
							char_stream.valid <= 1'b1;
							char_stream.ch <= datain;
							if (comma_cnt == CNT_W'(PREAMBLE_LEN - 1)) begin
								state <= line_code_pkg::PAYLOAD; // Last comma
							end else begin
								comma_cnt <= comma_cnt + 1'b1;
							end
						end else begin
							state <= line_code_pkg::IDLE; // Broken preamble, char dropped
						end
					end
				end
				line_code_pkg::PAYLOAD: begin
					if (pushin) begin
						char_stream.valid <= 1'b1;
						char_stream.ch <= datain;
						if (is_end) begin
							state <= line_code_pkg::CRC_TAIL; // K23.7 itself is forwarded
						end
					end
				end
				line_code_pkg::CRC_TAIL: begin
					char_stream.valid <= 1'b1;
					char_stream.ch.is_k <= 1'b0; // Sent as data characters
					char_stream.ch.value <= crc_value[{crc_idx, 3'b000} +: 8];
					crc_idx <= crc_idx + 1'b1; // Wraps back to 0 after byte 3
					if (crc_idx == 2'd3) begin
						state <= line_code_pkg::CLOSE;
					end
				end
				line_code_pkg::CLOSE: begin
					char_stream.valid <= 1'b1;
					char_stream.ch.is_k <= 1'b1;
					char_stream.ch.value <= line_code_pkg::K28_5;
					state <= line_code_pkg::IDLE;
				end
				default: begin
					state <= line_code_pkg::IDLE;
				end
			endcase
		end
	end
endmodule

// File: sub_block_6b.sv
`timescale 1ns/1ns

module sub_block_6b (
	input logic [4:0] value, // EDCBA
	input logic is_k,
	input logic rd_pos, // Running disparity before this block
	output logic [5:0] code6, // abcdei
	output logic flip6 // Code is unbalanced
);
	logic [5:0] neg_code; // RD- form
	logic is_k28;
	logic balanced;

	assign is_k28 = is_k && (value == line_code_pkg::K28_X);

	always_comb begin
		if (is_k28) begin
			neg_code = 6'b001111; // Only K28 has its own 6b code
		end else begin
			case (value)
				5'd0: neg_code = 6'b100111;
				5'd1: neg_code = 6'b011101;
				5'd2: neg_code = 6'b101101;
				5'd3: neg_code = 6'b110001;
				5'd4: neg_code = 6'b110101;
				5'd5: neg_code = 6'b101001;
				5'd6: neg_code = 6'b011001;
				5'd7: neg_code = 6'b111000; // Balanced but still alternates
				5'd8: neg_code = 6'b111001;
				5'd9: neg_code = 6'b100101;
				5'd10: neg_code = 6'b010101;
				5'd11: neg_code = 6'b110100;
				5'd12: neg_code = 6'b001101;
				5'd13: neg_code = 6'b101100;
				5'd14: neg_code = 6'b011100;
				5'd15: neg_code = 6'b010111;
				5'd16: neg_code = 6'b011011;
				5'd17: neg_code = 6'b100011;
				5'd18: neg_code = 6'b010011;
				5'd19: neg_code = 6'b110010;
				5'd20: neg_code = 6'b001011;
				5'd21: neg_code = 6'b101010;
				5'd22: neg_code = 6'b011010;
				5'd23: neg_code = 6'b111010; // Also K23
				5'd24: neg_code = 6'b110011;
				5'd25: neg_code = 6'b100110;
				5'd26: neg_code = 6'b010110;
				5'd27: neg_code = 6'b110110; // Also K27
				5'd28: neg_code = 6'b001110;
				5'd29: neg_code = 6'b101110; // Also K29
				5'd30: neg_code = 6'b011110; // Also K30
				default: neg_code = 6'b101011; // D.31
			endcase
		end
	end

	// Three ones means neutral
	assign balanced = ($countones(neg_code) == 3);
	assign flip6 = !balanced;

	// D.07 swaps even though neutral
	always_comb begin
		if (rd_pos && (!balanced || ((value == 5'd7) && !is_k))) begin
			code6 = ~neg_code;
		end else begin
			code6 = neg_code;
		end
	end
endmodule

// File: encoder_8b10b.sv
`timescale 1ns/1ns

module encoder_8b10b (
	input logic clk,
	input logic reset,
	input line_code_pkg::code_t char_stream,
	output logic pushout,
	output logic startout, // With first comma only
	output line_code_pkg::symbol_t dataout
);
	logic rd_pos; // Running disparity, 0 is RD-
	logic [4:0] x_val; // EDCBA
	logic [2:0] y_val; // HGF
	logic [5:0] code6;
	logic flip6;
	logic rd_mid; // Disparity between sub-blocks
	logic is_k28;
	logic use_a7;
	logic [3:0] base4; // RD- form
	logic [3:0] alt4; // RD+ form
	logic [3:0] code4;
	logic flip4;

	assign x_val = char_stream.ch.value[4:0];
	assign y_val = char_stream.ch.value[7:5];

	sub_block_6b u_sub_6b (
		.value(x_val),
		.is_k(char_stream.ch.is_k),
		.rd_pos(rd_pos),
		.code6(code6),
		.flip6(flip6)
	);

	assign rd_mid = rd_pos ^ flip6;
	assign is_k28 = char_stream.ch.is_k && (x_val == line_code_pkg::K28_X);

	// A7 avoids a run of five equal bits across the sub-block edge
	assign use_a7 = (y_val == 3'd7) && (char_stream.ch.is_k
		|| (!rd_mid && ((x_val == 5'd17) || (x_val == 5'd18) || (x_val == 5'd20)))
		|| (rd_mid && ((x_val == 5'd11) || (x_val == 5'd13) || (x_val == 5'd14))));

	always_comb begin
		case (y_val)
			3'd0: base4 = 4'b1011;
			3'd1: base4 = 4'b1001;
			3'd2: base4 = 4'b0101;
			3'd3: base4 = 4'b1100; // Neutral but alternates
			3'd4: base4 = 4'b1101;
			3'd5: base4 = 4'b1010;
			3'd6: base4 = 4'b0110;
			default: base4 = use_a7 ? 4'b0111 : 4'b1110; // A7 or P7
		endcase
	end

	assign flip4 = ($countones(base4) != 2);
	assign alt4 = (flip4 || (y_val == 3'd3)) ? ~base4 : base4;

	// K28 after RD+ is the exact complement of its RD- symbol
	always_comb begin
		if (rd_mid) begin
			code4 = alt4;
		end else if (is_k28) begin
			code4 = ~alt4;
		end else begin
			code4 = base4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pushout <= 1'b0;
			startout <= 1'b0;
			rd_pos <= 1'b0; // Start at RD-
		end else begin
			pushout <= char_stream.valid;
			startout <= char_stream.valid && char_stream.start;
			if (char_stream.valid) begin
				rd_pos <= rd_mid ^ flip4; // Holds in gaps
			end
		end
	end

	always_ff @(posedge clk) begin
		if (char_stream.valid) begin
			dataout <= {code6, code4};
		end
	end
endmodule

// File: framed_encoder.sv
`timescale 1ns/1ns

module framed_encoder #(
	parameter int PREAMBLE_LEN = 4 // Commas per frame, two or more
) (
	input logic clk,
	input logic reset,
	input logic pushin,
	input logic startin,
	input line_code_pkg::char_t datain,
	output logic pushout,
	output logic startout,
	output line_code_pkg::symbol_t dataout
);
	line_code_pkg::code_t char_stream; // Framer to encoder
	line_code_pkg::crc_t crc_value;
	line_code_pkg::byte_t crc_byte;
	logic crc_clear;
	logic crc_update;

	frame_ctrl #(
		.PREAMBLE_LEN(PREAMBLE_LEN)
	) u_frame_ctrl (
		.clk(clk),
		.reset(reset),
		.pushin(pushin),
		.startin(startin),
		.datain(datain),
		.crc_value(crc_value),
		.crc_clear(crc_clear),
		.crc_update(crc_update),
		.crc_byte(crc_byte),
		.char_stream(char_stream)
	);

	crc32_accum u_crc32_accum (
		.clk(clk),
		.reset(reset),
		.crc_clear(crc_clear),
		.crc_update(crc_update),
		.data(crc_byte),
		.crc_value(crc_value)
	);

	encoder_8b10b u_encoder (
		.clk(clk),
		.reset(reset),
		.char_stream(char_stream),
		.pushout(pushout),
		.startout(startout),
		.dataout(dataout)
	);
endmodule

// File: tb_framed_encoder.sv
`timescale 1ns/1ns

module tb_framed_encoder;
	localparam int PREAMBLE_LEN = 4;
	localparam int PAYLOAD_LEN = 24; // Characters per random frame
	localparam int N_FRAMES = 8; // Frames over all tests
	localparam int FRAME_CYCLES = 20 + 2 * PAYLOAD_LEN; // Worst case with gaps and drain
	localparam int STIM_CYCLES = 60 + N_FRAMES * FRAME_CYCLES;
	localparam int TIMEOUT_CYCLES = 3 * STIM_CYCLES;

	// RD- 5b/6b codes abcdei with D.31 first
	localparam logic [191:0] SIX_NEG = {
		6'b101011, 6'b011110, 6'b101110, 6'b001110, 6'b110110, 6'b010110, 6'b100110, 6'b110011,
		6'b111010, 6'b011010, 6'b101010, 6'b001011, 6'b110010, 6'b010011, 6'b100011, 6'b011011,
		6'b010111, 6'b011100, 6'b101100, 6'b001101, 6'b110100, 6'b010101, 6'b100101, 6'b111001,
		6'b111000, 6'b011001, 6'b101001, 6'b110101, 6'b110001, 6'b101101, 6'b011101, 6'b100111};
	// RD- 3b/4b codes fghj with x.7 first
	localparam logic [31:0] D_FOUR_NEG = {4'b1110, 4'b0110, 4'b1010, 4'b1101,
		4'b1100, 4'b0101, 4'b1001, 4'b1011}; // P7 in top slot
	localparam logic [31:0] K_FOUR_NEG = {4'b0111, 4'b1001, 4'b0101, 4'b1101,
		4'b1100, 4'b1010, 4'b0110, 4'b1011};

	logic clk;
	logic reset;
	logic pushin;
	logic startin;
	line_code_pkg::char_t datain;
	logic pushout;
	logic startout;
	line_code_pkg::symbol_t dataout;

	logic [11:0] exp_q[$]; // {follow, start, symbol}
	logic ref_rd; // Reference disparity with 1 as RD+
	logic [31:0] crc_run; // Uncomplemented running CRC
	logic [31:0] lfsr;
	logic prev_push;
	int errors;
	int checked;
	int starts;
	int tests_run;
	int cycle_cnt;

	framed_encoder #(.PREAMBLE_LEN(PREAMBLE_LEN)) dut0 (
		.clk(clk), .reset(reset), .pushin(pushin), .startin(startin), .datain(datain),
		.pushout(pushout), .startout(startout), .dataout(dataout)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// Returns {new_rd, abcdei, fghj}
	function automatic logic [10:0] ref_encode(input logic is_k, input logic [7:0] v,
			input logic rd);
		logic [5:0] six;
		logic [3:0] four;
		logic [4:0] x;
		logic [2:0] y;
		logic rd6;
		logic a7;
		x = v[4:0];
		y = v[7:5];
		six = (is_k && x == 5'd28) ? 6'b001111 : SIX_NEG[x*6 +: 6];
		if (rd && (($countones(six) != 3) || (x == 5'd7 && !is_k))) begin
			six = ~six; // RD+ column
		end
		rd6 = rd ^ ($countones(six) != 3);
		if (is_k) begin
			four = rd6 ? ~K_FOUR_NEG[y*4 +: 4] : K_FOUR_NEG[y*4 +: 4];
		end else begin
			four = D_FOUR_NEG[y*4 +: 4];
			a7 = (y == 3'd7) && (rd6 ? (x == 5'd11 || x == 5'd13 || x == 5'd14)
				: (x == 5'd17 || x == 5'd18 || x == 5'd20));
			if (a7) begin
				four = 4'b0111;
			end
			if (rd6 && (($countones(four) != 2) || y == 3'd3)) begin
				four = ~four;
			end
		end
		return {rd6 ^ ($countones(four) != 2), six, four};
	endfunction

	// Reflected CRC-32 with the byte folded in before the shifts
	function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
		logic [31:0] c;
		c = crc ^ {24'd0, b};
		for (int i = 0; i < 8; i++) begin
			c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
		end
		return c;
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr); // One step per bit
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic expect_sym(input logic is_k, input logic [7:0] v, input logic start,
			input logic follow);
		logic [10:0] r;
		r = ref_encode(is_k, v, ref_rd);
		ref_rd = r[10];
		exp_q.push_back({follow, start, r[9:0]});
	endtask

	task automatic send_char(input logic is_k, input logic [7:0] v, input logic start,
			input logic accepted);
		@(posedge clk);
		pushin <= 1'b1;
		startin <= start;
		datain <= {is_k, v};
		if (accepted) begin
			expect_sym(is_k, v, start, 1'b0);
		end
		if (accepted && !is_k) begin
			crc_run = crc_step(crc_run, v); // Payload data only
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			pushin <= 1'b0;
			startin <= 1'b0;
		end
	endtask

	task automatic send_preamble(input int n);
		for (int i = 0; i < n; i++) begin
			send_char(1'b1, line_code_pkg::K28_1, i == 0, 1'b1);
		end
		crc_run = 32'hFFFF_FFFF; // New frame
	endtask

	// End character followed back to back by four CRC bytes LSB first and K28.5
	task automatic close_frame;
		logic [31:0] crc;
		send_char(1'b1, line_code_pkg::K23_7, 1'b0, 1'b1);
		crc = ~crc_run;
		for (int i = 0; i < 4; i++) begin
			expect_sym(1'b0, crc[i*8 +: 8], 1'b0, 1'b1);
		end
		expect_sym(1'b1, line_code_pkg::K28_5, 1'b0, 1'b1);
		idle(8);
	endtask

	task automatic random_frame(input logic with_ctrl);
		logic [7:0] v;
		logic [7:0] pick;
		send_preamble(PREAMBLE_LEN);
		for (int i = 0; i < PAYLOAD_LEN; i++) begin
			if (rand_bits(2) == 8'd0) begin
				idle(1); // Gap in the input strobe
			end
			if (with_ctrl && rand_bits(2) == 8'd0) begin
				pick = rand_bits(4);
				if (pick < 8'd8) begin
					v = {pick[2:0], 5'd28}; // K28.y
				end else begin
					v = {3'd7, pick[0] ? 5'd29 : (pick[1] ? 5'd30 : 5'd27)};
				end
				send_char(1'b1, v, 1'b0, 1'b1);
			end else begin
				send_char(1'b0, rand_bits(8), 1'b0, 1'b1);
			end
		end
		close_frame();
	endtask

	task automatic end_test(input string name, input int errs_before);
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk); // Catch stray symbols
		tests_run++;
		$display("Test %s finished with %0d errors", name, errors - errs_before);
	endtask

	always @(negedge clk) begin : compare
		logic [11:0] e;
		if (!reset && pushout) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("ERROR at %0t: symbol %b came out with nothing expected",
					$time, dataout);
			end else begin
				e = exp_q.pop_front();
				checked++;
				if (dataout !== e[9:0] || startout !== e[10]) begin
					errors++;
					$display("ERROR at %0t: expected %b start %b, got %b start %b",
						$time, e[9:0], e[10], dataout, startout);
				end
				if (e[11] && !prev_push) begin
					errors++;
					$display("ERROR at %0t: tail symbol %b came after a gap", $time, e[9:0]);
				end
			end
			if (startout) begin
				starts++;
			end
		end else if (!reset && startout) begin
			errors++;
			$display("ERROR at %0t: startout high without pushout", $time);
		end
		prev_push = pushout;
	end

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout reached after %0d cycles with %0d expected symbols still pending",
			cycle_cnt, exp_q.size());
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin : main
		int errs;
		logic [31:0] check_crc;
		reset = 1'b1;
		pushin = 1'b0;
		startin = 1'b0;
		datain = '0;
		lfsr = 32'h4590_5785;
		ref_rd = 1'b0; // RD- after reset
		crc_run = 32'hFFFF_FFFF;
		prev_push = 1'b0;
		errors = 0;
		checked = 0;
		starts = 0;
		tests_run = 0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		errs = errors;
		repeat (12) begin
			@(negedge clk);
			if (pushout !== 1'b0 || startout !== 1'b0) begin
				errors++;
				$display("ERROR at %0t: output strobe high before any input", $time);
			end
		end
		end_test("reset_quiet", errs);

		errs = errors;
		send_preamble(PREAMBLE_LEN);
		for (int i = 0; i < 3; i++) begin
			send_char(1'b0, rand_bits(8), 1'b0, 1'b1);
		end
		close_frame();
		end_test("preamble", errs);
		if (starts != 1) begin
			errors++;
			$display("Saw %0d startout pulses for one frame instead of one", starts);
		end

		errs = errors;
		repeat (3) random_frame(1'b0);
		end_test("random_data", errs);

		errs = errors;
		repeat (2) random_frame(1'b1);
		end_test("control_chars", errs);

		errs = errors;
		check_crc = 32'hFFFF_FFFF;
		for (int i = 0; i < 9; i++) begin
			check_crc = crc_step(check_crc, 8'h31 + 8'(i)); // ASCII 1 to 9
		end
		if (~check_crc != 32'hCBF4_3926) begin
			errors++;
			$display("Reference CRC gives %h for the standard check string", ~check_crc);
		end
		send_preamble(PREAMBLE_LEN);
		for (int i = 0; i < 9; i++) begin
			send_char(1'b0, 8'h31 + 8'(i), 1'b0, 1'b1);
		end
		close_frame();
		end_test("crc_tail", errs);

		errs = errors;
		send_preamble(2);
		send_char(1'b0, 8'hA5, 1'b0, 1'b0); // Breaks the preamble and is dropped
		idle(3);
		random_frame(1'b0);
		end_test("broken_preamble", errs);

		$display("Tests run %0d, symbols checked %0d, errors %0d", tests_run, checked, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end
endmodule

// File: framed_encoder.f
line_code_pkg.sv
crc32_accum.sv
frame_ctrl.sv
sub_block_6b.sv
encoder_8b10b.sv
framed_encoder.sv
tb_framed_encoder.sv

// File: Makefile
# Verilator simulation of the framed 8b/10b encoder

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

obj_dir/Vtb_framed_encoder: framed_encoder.f *.sv
	verilator --binary --timing --top-module tb_framed_encoder \
		-f framed_encoder.f --Mdir obj_dir

test: obj_dir/Vtb_framed_encoder
	@out="$$(./obj_dir/Vtb_framed_encoder)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
